// File: Bender.yml
package:
  name: eth_mii

sources:
  - source/eth_pkg.sv
  - source/eth_frame_buffer.sv
  - source/eth_host_regs.sv
  - source/eth_tx_mii.sv
  - source/eth_rx_mii.sv
  - source/eth_core.sv
  - target: simulation
    files:
      - sim/eth_checker.sv
      - sim/eth_tb.sv

// File: compile.f
source/eth_pkg.sv
source/eth_frame_buffer.sv
source/eth_host_regs.sv
source/eth_tx_mii.sv
source/eth_rx_mii.sv
source/eth_core.sv
sim/eth_checker.sv
sim/eth_tb.sv

// File: sim/eth_checker.sv
`timescale 1ns/1ps

module eth_checker
   import eth_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        eth_resetn,
   input logic        tx_en,
   input logic [3:0]  tx_data,
   input logic [31:0] data_out
);

   int          errors;
   int          low_cycles;
   logic        resetn_seen;
   logic        tx_en_q;
   logic [3:0]  nib_exp;
   logic [31:0] rd_exp_val;
   logic [3:0]  tx_exp[$];
   logic [31:0] rd_exp[$];

   initial begin
      errors      = 0;
      low_cycles  = 0;
      resetn_seen = 1'b0;
      tx_en_q     = 1'b0;
   end

   task automatic expect_nibble(input logic [3:0] nib);
      tx_exp.push_back(nib);
   endtask

   // compared in the middle of the cycle after the read
   task automatic expect_read(input logic [31:0] value);
      rd_exp.push_back(value);
   endtask

   task automatic check_empty();
      if (tx_exp.size() != 0) begin
         errors++;
         $display("ERROR: %0d transmit nibbles were never sent", tx_exp.size());
      end
   endtask

   // sample at the falling edge away from register updates
   always @(negedge clk) begin
      if (rst) begin
         low_cycles  = 0;
         resetn_seen = 1'b0;
         tx_en_q     = 1'b0;
      end else begin
         if (!eth_resetn) begin
            if (resetn_seen) begin
               errors++;
               $display("ERROR: eth_resetn fell again after the phy reset ended");
            end
            low_cycles++;
         end else if (!resetn_seen) begin
            resetn_seen = 1'b1;
            if (low_cycles != phy_rst_cycles) begin
               errors++;
               $display("CHECK FAILED eth_resetn low cycles: expected %h, got %h",
                        phy_rst_cycles, low_cycles);
            end
         end

         if (tx_en) begin
            if (tx_exp.size() == 0) begin
               errors++;
               $display("ERROR: tx_en is high while no frame nibble is expected");
            end else begin
               nib_exp = tx_exp.pop_front();
               if (tx_data !== nib_exp) begin
                  errors++;
                  $display("CHECK FAILED tx_data: expected %h, got %h", nib_exp, tx_data);
               end
            end
         end else if (tx_en_q && (tx_exp.size() != 0)) begin
            errors++;
            $display("ERROR: tx_en fell with %0d nibbles of the frame left", tx_exp.size());
            tx_exp.delete();
         end
         tx_en_q = tx_en;

         if (rd_exp.size() != 0) begin
            rd_exp_val = rd_exp.pop_front();
            if (data_out !== rd_exp_val) begin
               errors++;
               $display("CHECK FAILED data_out: expected %h, got %h", rd_exp_val, data_out);
            end
         end
      end
   end

endmodule

// File: sim/eth_tb.sv
`timescale 1ns/1ps

module eth_tb
   import eth_pkg::*;
();

   localparam int timeout_cycles = 2000;

   logic              clk;
   logic              rst;
   logic              sel;
   logic              we;
   logic [addr_w-1:0] addr;
   logic [31:0]       data_in;
   logic [31:0]       data_out;
   logic              eth_resetn;
   logic              rx_dv;
   logic [3:0]        rx_data;
   logic              tx_en;
   logic [3:0]        tx_data;

   integer      seed;
   int          timeouts;
   int          n;
   int          k;
   int          m;
   int          j;
   int          pass;
   logic [7:0]  b;
   logic [31:0] val;
   logic [7:0]  tx_img [buf_depth];
   logic [7:0]  rx_img [buf_depth];
   logic        rx_known [buf_depth];

   eth_core dut_i (
      .clk        (clk),
      .rst        (rst),
      .sel        (sel),
      .we         (we),
      .addr       (addr),
      .data_in    (data_in),
      .data_out   (data_out),
      .eth_resetn (eth_resetn),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .tx_en      (tx_en),
      .tx_data    (tx_data)
   );

   eth_checker chk (
      .clk        (clk),
      .rst        (rst),
      .eth_resetn (eth_resetn),
      .tx_en      (tx_en),
      .tx_data    (tx_data),
      .data_out   (data_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [addr_w-1:0] window_addr(input int idx);
      return {1'b1, buf_addr_w'(idx)};
   endfunction

   function automatic logic [addr_w-1:0] reg_addr(input eth_reg_e r);
      return addr_w'(r);
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic host_write(input logic [addr_w-1:0] a, input logic [31:0] d);
      sel     = 1'b1;
      we      = 1'b1;
      addr    = a;
      data_in = d;
      tick();
      sel = 1'b0;
      we  = 1'b0;
   endtask

   task automatic host_read(input logic [addr_w-1:0] a, output logic [31:0] d);
      sel  = 1'b1;
      we   = 1'b0;
      addr = a;
      tick();
      sel = 1'b0;
      d   = data_out;
   endtask

   task automatic read_expect(input logic [addr_w-1:0] a, input logic [31:0] exp);
      logic [31:0] d;
      host_read(a, d);
      chk.expect_read(exp);
   endtask

   task automatic wait_status(input logic [31:0] mask, input string what);
      logic [31:0] d;
      int          cnt;
      cnt = 0;
      host_read(reg_addr(reg_status), d);
      while (((d & mask) != mask) && (cnt < timeout_cycles)) begin
         host_read(reg_addr(reg_status), d);
         cnt++;
      end
      if ((d & mask) != mask) begin
         timeouts++;
         $display("ERROR: timed out waiting for %s", what);
      end
   endtask

   task automatic wait_resetn();
      int cnt;
      cnt = 0;
      while ((eth_resetn !== 1'b1) && (cnt < timeout_cycles)) begin
         tick();
         cnt++;
      end
      if (eth_resetn !== 1'b1) begin
         timeouts++;
         $display("ERROR: timed out waiting for eth_resetn");
      end
   endtask

   task automatic wait_tx_en(input logic level, input string what);
      int cnt;
      cnt = 0;
      while ((tx_en !== level) && (cnt < timeout_cycles)) begin
         tick();
         cnt++;
      end
      if (tx_en !== level) begin
         timeouts++;
         $display("ERROR: timed out waiting for %s", what);
      end
   endtask

   task automatic mii_nibble(input logic dv, input logic [3:0] nib);
      rx_dv   = dv;
      rx_data = nib;
      tick();
   endtask

   // low nibble goes out first
   task automatic mii_byte(input logic [7:0] byte_val);
      mii_nibble(1'b1, byte_val[3:0]);
      mii_nibble(1'b1, byte_val[7:4]);
   endtask

   task automatic mii_frame_start();
      repeat (3 + {$random(seed)} % 6) mii_nibble(1'b0, 4'($random(seed)));
      repeat (preamble_len) mii_byte(8'h55);
      mii_byte(8'hD5);
   endtask

   task automatic check_rx_buffer();
      for (int a = 0; a < 64; a++) begin
         if (rx_known[a]) begin
            read_expect(window_addr(a), {24'b0, rx_img[a]});
         end
      end
   endtask

   initial begin
      seed     = 87377;
      timeouts = 0;
      rst      = 1'b1;
      sel      = 1'b0;
      we       = 1'b0;
      addr     = '0;
      data_in  = '0;
      rx_dv    = 1'b0;
      rx_data  = '0;
      for (int i = 0; i < buf_depth; i++) begin
         rx_known[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // status stays 0 while the phy is in reset
      read_expect(reg_addr(reg_status), 32'h0);
      wait_resetn();
      read_expect(reg_addr(reg_status), 32'h3);

      repeat (8) begin
         val = $random(seed);
         host_write(reg_addr(reg_dummy), val);
         read_expect(reg_addr(reg_dummy), val);
      end

      for (pass = 0; pass < 4; pass++) begin
         n = (pass == 0) ? 0 : {$random(seed)} % 41;
         for (int i = 0; i < n; i++) begin
            b = $random(seed);
            tx_img[i] = b;
            host_write(window_addr(i), {24'b0, b});
         end
         host_write(reg_addr(reg_tx_nbytes), n);
         repeat (preamble_len * 2) chk.expect_nibble(4'h5);
         chk.expect_nibble(4'h5);
         chk.expect_nibble(4'hD);
         for (int i = 0; i < n; i++) begin
            chk.expect_nibble(tx_img[i][3:0]);
            chk.expect_nibble(tx_img[i][7:4]);
         end
         host_write(reg_addr(reg_control), 32'h1);
         wait_tx_en(1'b1, "tx_en to rise");
         read_expect(reg_addr(reg_status), 32'h2);
         // second send while busy must be dropped
         host_write(reg_addr(reg_control), 32'h1);
         wait_tx_en(1'b0, "tx_en to fall");
         wait_status(32'h1, "tx ready");
         read_expect(reg_addr(reg_status), 32'h3);
      end

      // receive stopped by the byte count
      // second frame has a smaller count so bytes past it must keep the first frame
      k = 8 + {$random(seed)} % 23;
      m = k + 1 + {$random(seed)} % 4;
      for (pass = 0; pass < 2; pass++) begin
         n = (pass == 0) ? m : k;
         host_write(reg_addr(reg_rx_nbytes), n);
         host_write(reg_addr(reg_control), 32'h2);
         mii_frame_start();
         for (int i = 0; i <= m; i++) begin
            b = $random(seed);
            if (i < n) begin
               rx_img[i]   = b;
               rx_known[i] = 1'b1;
            end
            mii_byte(b);
         end
         mii_nibble(1'b0, 4'h0);
         wait_status(32'h2, "rx ready after a counted frame");
         check_rx_buffer();
      end

      // receive cut short by rx_dv with odd and even nibble counts
      for (pass = 0; pass < 2; pass++) begin
         j = 1 + {$random(seed)} % (k - 1);
         host_write(reg_addr(reg_rx_nbytes), j + 2 + {$random(seed)} % 4);
         host_write(reg_addr(reg_control), 32'h2);
         mii_frame_start();
         for (int i = 0; i < j; i++) begin
            b = $random(seed);
            rx_img[i] = b;
            mii_byte(b);
         end
         if (pass == 0) begin
            mii_nibble(1'b1, 4'($random(seed)));
         end
         mii_nibble(1'b0, 4'h0);
         wait_status(32'h2, "rx ready after a short frame");
         check_rx_buffer();
      end

      repeat (4) tick();
      chk.check_empty();
      $display("check errors: %0d, timeouts: %0d", chk.errors, timeouts);
      if ((chk.errors == 0) && (timeouts == 0)) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: source/eth_core.sv
`timescale 1ns/1ps

module eth_core
   import eth_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              sel,
   input  logic              we,
   input  logic [addr_w-1:0] addr,
   input  logic [31:0]       data_in,
   output logic [31:0]       data_out,
   output logic              eth_resetn,
   input  logic              rx_dv,
   input  logic [3:0]        rx_data,
   output logic              tx_en,
   output logic [3:0]        tx_data
);

   logic                  tx_wr;
   logic [buf_addr_w-1:0] buf_addr;
   logic [buf_addr_w-1:0] tx_nbytes;
   logic [buf_addr_w-1:0] rx_nbytes;
   logic                  send;
   logic                  receive;
   logic                  tx_ready;
   logic                  rx_ready;
   logic [buf_addr_w-1:0] tx_rd_addr;
   logic [7:0]            tx_rd_data;
   logic                  rx_wr;
   logic [buf_addr_w-1:0] rx_wr_addr;
   logic [7:0]            rx_wr_data;
   logic [7:0]            rx_rd_data;

   eth_host_regs host_regs (
      .clk        (clk),
      .rst        (rst),
      .sel        (sel),
      .we         (we),
      .addr       (addr),
      .data_in    (data_in),
      .data_out   (data_out),
      .tx_wr      (tx_wr),
      .buf_addr   (buf_addr),
      .tx_nbytes  (tx_nbytes),
      .rx_nbytes  (rx_nbytes),
      .send       (send),
      .receive    (receive),
      .eth_resetn (eth_resetn),
      .tx_ready   (tx_ready),
      .rx_ready   (rx_ready),
      .rx_rd_data (rx_rd_data)
   );

   // host writes, transmitter reads
   eth_frame_buffer tx_buffer (
      .clk     (clk),
      .wr      (tx_wr),
      .wr_addr (buf_addr),
      .wr_data (data_in[7:0]),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data)
   );

   // receiver writes, host reads
   eth_frame_buffer rx_buffer (
      .clk     (clk),
      .wr      (rx_wr),
      .wr_addr (rx_wr_addr),
      .wr_data (rx_wr_data),
      .rd_addr (buf_addr),
      .rd_data (rx_rd_data)
   );

   eth_tx_mii tx_mii (
      .clk     (clk),
      .rst     (rst),
      .send    (send),
      .nbytes  (tx_nbytes),
      .ready   (tx_ready),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data),
      .tx_en   (tx_en),
      .tx_data (tx_data)
   );

   eth_rx_mii rx_mii (
      .clk     (clk),
      .rst     (rst),
      .receive (receive),
      .nbytes  (rx_nbytes),
      .ready   (rx_ready),
      .rx_dv   (rx_dv),
      .rx_data (rx_data),
      .wr      (rx_wr),
      .wr_addr (rx_wr_addr),
      .wr_data (rx_wr_data)
   );

endmodule

// File: source/eth_frame_buffer.sv
`timescale 1ns/1ps

module eth_frame_buffer
   import eth_pkg::*;
(
   input  logic                  clk,
   input  logic                  wr,
   input  logic [buf_addr_w-1:0] wr_addr,
   input  logic [7:0]            wr_data,
   input  logic [buf_addr_w-1:0] rd_addr,
   output logic [7:0]            rd_data
);

   logic [7:0] mem [buf_depth];

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read data is valid one cycle after the address
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: source/eth_host_regs.sv
`timescale 1ns/1ps

module eth_host_regs
   import eth_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sel,
   input  logic                  we,
   input  logic [addr_w-1:0]     addr,
   input  logic [31:0]           data_in,
   output logic [31:0]           data_out,
   output logic                  tx_wr,
   output logic [buf_addr_w-1:0] buf_addr,
   output logic [buf_addr_w-1:0] tx_nbytes,
   output logic [buf_addr_w-1:0] rx_nbytes,
   output logic                  send,
   output logic                  receive,
   output logic                  eth_resetn,
   input  logic                  tx_ready,
   input  logic                  rx_ready,
   input  logic [7:0]            rx_rd_data
);

   logic                 reg_sel;
   logic                 buf_sel;
   logic                 reg_wr;
   logic                 ctrl_wr;
   eth_reg_e             reg_id;
   logic [31:0]          reg_rd_val;
   logic [31:0]          reg_rd_q;
   logic                 rd_buf_q;
   logic [31:0]          dummy;
   logic [phy_cnt_w-1:0] phy_cnt;

   // address decode
   assign buf_sel  = sel && addr[addr_w-1];
   assign reg_sel  = sel && !addr[addr_w-1] && (addr[buf_addr_w-1:3] == '0);
   assign reg_id   = eth_reg_e'(addr[2:0]);
   assign reg_wr   = reg_sel && we;
   assign ctrl_wr  = reg_wr && (reg_id == reg_control);
   assign buf_addr = addr[buf_addr_w-1:0];
   assign tx_wr    = buf_sel && we;

   // commands only accepted once the phy is out of reset
   assign send    = ctrl_wr && data_in[0] && eth_resetn && tx_ready;
   assign receive = ctrl_wr && data_in[1] && eth_resetn && rx_ready;

   always_ff @(posedge clk) begin
      if (reg_wr && (reg_id == reg_dummy)) begin
         dummy <= data_in;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tx_nbytes <= '0;
         rx_nbytes <= '0;
      end else if (reg_wr) begin
         if (reg_id == reg_tx_nbytes) begin
            tx_nbytes <= data_in[buf_addr_w-1:0];
         end
         if (reg_id == reg_rx_nbytes) begin
            rx_nbytes <= data_in[buf_addr_w-1:0];
         end
      end
   end

   always_comb begin
      reg_rd_val = '0;
      if (reg_sel) begin
         case (reg_id)
            reg_status:    reg_rd_val = {30'b0, rx_ready & eth_resetn, tx_ready & eth_resetn};
            reg_dummy:     reg_rd_val = dummy;
            reg_tx_nbytes: reg_rd_val = {{(32-buf_addr_w){1'b0}}, tx_nbytes};
            reg_rx_nbytes: reg_rd_val = {{(32-buf_addr_w){1'b0}}, rx_nbytes};
            default:       reg_rd_val = '0;
         endcase
      end
   end

   // buffer bytes come straight from the registered memory port
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         reg_rd_q <= '0;
         rd_buf_q <= 1'b0;
      end else if (sel && !we) begin
         reg_rd_q <= reg_rd_val;
         rd_buf_q <= buf_sel;
      end
   end

   assign data_out = rd_buf_q ? {24'b0, rx_rd_data} : reg_rd_q;

   // phy reset, low for phy_rst_cycles after rst
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phy_cnt    <= '0;
         eth_resetn <= 1'b0;
      end else if (!eth_resetn) begin
         phy_cnt <= phy_cnt + 1'b1;
         if (phy_cnt == phy_cnt_w'(phy_rst_cycles - 1)) begin
            eth_resetn <= 1'b1;
         end
      end
   end

endmodule

// File: source/eth_pkg.sv
package eth_pkg;

   // host address map
   localparam int addr_w     = 12;
   localparam int buf_addr_w = 11;
   localparam int buf_depth  = 2048;

   // phy reset timer
   localparam int phy_rst_cycles = 64;
   localparam int phy_cnt_w      = $clog2(phy_rst_cycles);

   // frame constants
   localparam logic [7:0] preamble_byte = 8'h55;
   localparam logic [7:0] sfd_byte      = 8'hD5;
   localparam int         preamble_len  = 7;

   // register offsets, valid when addr[11] is clear
   typedef enum logic [2:0] {
      reg_status    = 3'd0,
      reg_dummy     = 3'd1,
      reg_control   = 3'd2,
      reg_tx_nbytes = 3'd3,
      reg_rx_nbytes = 3'd4
   } eth_reg_e;

   typedef enum logic [1:0] {
      tx_idle,
      tx_preamble,
      tx_sfd,
      tx_payload
   } tx_state_e;

   typedef enum logic [1:0] {
      rx_idle,
      rx_hunt,
      rx_payload
   } rx_state_e;

endpackage

// File: source/eth_rx_mii.sv
`timescale 1ns/1ps

module eth_rx_mii
   import eth_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  receive,
   input  logic [buf_addr_w-1:0] nbytes,
   output logic                  ready,
   input  logic                  rx_dv,
   input  logic [3:0]            rx_data,
   output logic                  wr,
   output logic [buf_addr_w-1:0] wr_addr,
   output logic [7:0]            wr_data
);

   rx_state_e             state;
   logic [buf_addr_w-1:0] cnt;
   logic [buf_addr_w-1:0] nbytes_q;
   logic                  phase;
   logic                  prev_5;
   logic [3:0]            low_nib;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= rx_idle;
         cnt      <= '0;
         nbytes_q <= '0;
         phase    <= 1'b0;
         prev_5   <= 1'b0;
         ready    <= 1'b1;
         wr       <= 1'b0;
      end else begin
         wr     <= 1'b0;
         prev_5 <= rx_dv && (rx_data == sfd_byte[3:0]);
         case (state)
            rx_idle: begin
               if (receive) begin
                  state    <= rx_hunt;
                  nbytes_q <= nbytes;
                  ready    <= 1'b0;
               end
            end
            rx_hunt: begin
               // delimiter is 0x5 then 0xd on the wire
               if (rx_dv && prev_5 && (rx_data == sfd_byte[7:4])) begin
                  state <= rx_payload;
                  cnt   <= '0;
                  phase <= 1'b0;
               end
            end
            rx_payload: begin
               if ((cnt == nbytes_q) || !rx_dv) begin
                  // a pending half byte is dropped here
                  state <= rx_idle;
                  ready <= 1'b1;
               end else begin
                  phase <= !phase;
                  if (phase) begin
                     wr  <= 1'b1;
                     cnt <= cnt + 1'b1;
                  end
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // byte assembly
   always_ff @(posedge clk) begin
      if ((state == rx_payload) && rx_dv) begin
         if (!phase) begin
            low_nib <= rx_data;
         end else begin
            wr_addr <= cnt;
            wr_data <= {rx_data, low_nib};
         end
      end
   end

endmodule

// File: source/eth_tx_mii.sv
`timescale 1ns/1ps

module eth_tx_mii
   import eth_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  send,
   input  logic [buf_addr_w-1:0] nbytes,
   output logic                  ready,
   output logic [buf_addr_w-1:0] rd_addr,
   input  logic [7:0]            rd_data,
   output logic                  tx_en,
   output logic [3:0]            tx_data
);

   tx_state_e             state;
   logic [buf_addr_w-1:0] cnt;
   logic [buf_addr_w-1:0] nbytes_q;
   logic                  phase;
   logic [7:0]            cur_byte;

   always_comb begin
      case (state)
         tx_preamble: cur_byte = preamble_byte;
         tx_sfd:      cur_byte = sfd_byte;
         tx_payload:  cur_byte = rd_data;
         default:     cur_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= tx_idle;
         cnt      <= '0;
         nbytes_q <= '0;
         phase    <= 1'b0;
         rd_addr  <= '0;
         ready    <= 1'b1;
         tx_en    <= 1'b0;
         tx_data  <= '0;
      end else begin
         // low nibble first
         tx_en   <= (state != tx_idle);
         tx_data <= phase ? cur_byte[7:4] : cur_byte[3:0];
         phase   <= (state != tx_idle) && !phase;
         case (state)
            tx_idle: begin
               if (send) begin
                  state    <= tx_preamble;
                  nbytes_q <= nbytes;
                  cnt      <= '0;
                  rd_addr  <= '0;
                  ready    <= 1'b0;
               end else if (!tx_en) begin
                  // back to ready once the last nibble has left
                  ready <= 1'b1;
               end
            end
            tx_preamble: begin
               if (phase) begin
                  cnt <= cnt + 1'b1;
                  if (cnt == buf_addr_w'(preamble_len - 1)) begin
                     state <= tx_sfd;
                  end
               end
            end
            tx_sfd: begin
               if (phase) begin
                  cnt   <= '0;
                  state <= (nbytes_q == '0) ? tx_idle : tx_payload;
               end
            end
            tx_payload: begin
               if (!phase) begin
                  // fetch next byte while the high nibble goes out
                  rd_addr <= cnt + 1'b1;
               end else begin
                  cnt <= cnt + 1'b1;
                  if (cnt == nbytes_q - 1'b1) begin
                     state <= tx_idle;
                  end
               end
            end
            default: state <= tx_idle;
         endcase
      end
   end

endmodule
